/* bch_codec.f */
source/bch_pkg.sv
source/axil_pkg.sv
source/axil_regs.sv
source/bch_encoder.sv
source/bch_decoder.sv
source/bch_sequencer.sv
source/bch_codec.sv
verification/bch_codec_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the BCH codec testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module bch_codec_tb -Mdir obj_dir -f bch_codec.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vbch_codec_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
exit 1

/* source/axil_pkg.sv */
package axil_pkg;

    localparam int AXIL_ADDR_W = 5;
    localparam int AXIL_DATA_W = 32;

    // master side of the bus
    typedef struct packed {
        logic                     awvalid;
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     wvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     bready;
        logic                     arvalid;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     rready;
    } axil_req_t;

    // slave side of the bus
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

    typedef enum logic [AXIL_ADDR_W-1:0] {
        MESSAGE     = 5'h00,
        ERR_MASK    = 5'h04,
        RX_WORD     = 5'h08,
        COMMAND     = 5'h0c,
        STATUS      = 5'h10,
        CODEWORD    = 5'h14,
        CORRECTED   = 5'h18,
        DEC_MESSAGE = 5'h1c
    } reg_addr_e;

    typedef enum logic [1:0] {
        CMD_ENCODE = 2'd1,
        CMD_DECODE = 2'd2,
        CMD_LOOP   = 2'd3
    } cmd_e;

    typedef struct packed {
        bch_pkg::message_t  message;
        bch_pkg::codeword_t err_mask;
        bch_pkg::codeword_t rx_word;
        cmd_e               cmd;
        logic               start;      // one cycle per accepted command
    } codec_cfg_t;

endpackage

/* source/axil_regs.sv */
`timescale 1ns/1ps

module axil_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  axil_pkg::axil_req_t    s_axil_req,
    output axil_pkg::axil_rsp_t    s_axil_rsp,
    output axil_pkg::codec_cfg_t   cfg,
    input  bch_pkg::codec_status_t status,
    input  bch_pkg::codeword_t     codeword,
    input  bch_pkg::dec_result_t   result
);

    typedef logic [axil_pkg::AXIL_DATA_W-1:0] word_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic               wr_ready;
    logic               bvalid;
    logic [1:0]         bresp;
    logic               rd_ready;
    logic               rvalid;
    logic [1:0]         rresp;
    word_t              rdata;
    bch_pkg::message_t  msg_r;
    bch_pkg::codeword_t mask_r;
    bch_pkg::codeword_t rx_r;
    axil_pkg::cmd_e     cmd_r;
    logic               start_r;
    word_t              wr_old;
    word_t              wr_new;
    word_t              rd_word;
    logic               wr_ok;
    logic               cmd_ok;
    logic               rd_ok;

    function automatic word_t merge_strb(input word_t old_v, input word_t new_v,
                                         input logic [axil_pkg::AXIL_DATA_W/8-1:0] strb);
        word_t res;
        res = old_v;
        for (int b = 0; b < axil_pkg::AXIL_DATA_W / 8; b++)
        begin
            if (strb[b])
                res[8*b +: 8] = new_v[8*b +: 8];
        end
        return res;
    endfunction

    // --------------------
    // write path
    // --------------------
    always_comb
    begin
        wr_old = '0;
        wr_ok  = 1'b1;
        cmd_ok = (s_axil_req.wdata[axil_pkg::AXIL_DATA_W-1:2] == '0) &&
                 (s_axil_req.wdata[1:0] inside {axil_pkg::CMD_ENCODE, axil_pkg::CMD_DECODE,
                                                axil_pkg::CMD_LOOP});
        case (s_axil_req.awaddr)
            axil_pkg::MESSAGE:  wr_old = word_t'(msg_r);
            axil_pkg::ERR_MASK: wr_old = word_t'(mask_r);
            axil_pkg::RX_WORD:  wr_old = word_t'(rx_r);
            axil_pkg::COMMAND:  wr_ok  = cmd_ok && !status.busy && !start_r;   // refuse, never queue
            default:            wr_ok  = 1'b0;
        endcase
        wr_new = merge_strb(wr_old, s_axil_req.wdata, s_axil_req.wstrb);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= RESP_OKAY;
            start_r  <= 1'b0;
            msg_r    <= '0;
            mask_r   <= '0;
            rx_r     <= '0;
            cmd_r    <= axil_pkg::CMD_ENCODE;
        end
        else
        begin
            wr_ready <= 1'b0;
            start_r  <= 1'b0;
            if (bvalid && s_axil_req.bready)
                bvalid <= 1'b0;
            if (wr_ready)                                   // handshake cycle
            begin
                bvalid <= 1'b1;
                bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
                if (wr_ok)
                begin
                    case (s_axil_req.awaddr)
                        axil_pkg::MESSAGE:  msg_r  <= wr_new[bch_pkg::MSG_K-1:0];
                        axil_pkg::ERR_MASK: mask_r <= wr_new[bch_pkg::CODE_N-1:0];
                        axil_pkg::RX_WORD:  rx_r   <= wr_new[bch_pkg::CODE_N-1:0];
                        default:
                        begin
                            cmd_r   <= axil_pkg::cmd_e'(s_axil_req.wdata[1:0]);
                            start_r <= 1'b1;
                        end
                    endcase
                end
            end
            else if (s_axil_req.awvalid && s_axil_req.wvalid && !bvalid)
                wr_ready <= 1'b1;
        end
    end

    // --------------------
    // read path
    // --------------------
    always_comb
    begin
        rd_word = '0;
        rd_ok   = 1'b1;
        case (s_axil_req.araddr)
            axil_pkg::MESSAGE:     rd_word = word_t'(msg_r);
            axil_pkg::ERR_MASK:    rd_word = word_t'(mask_r);
            axil_pkg::RX_WORD:     rd_word = word_t'(rx_r);
            axil_pkg::COMMAND:     rd_word = word_t'(cmd_r);
            axil_pkg::STATUS:      rd_word = word_t'(status);
            axil_pkg::CODEWORD:    rd_word = word_t'(codeword);
            axil_pkg::CORRECTED:   rd_word = word_t'(result.corrected);
            axil_pkg::DEC_MESSAGE: rd_word = word_t'(result.message);
            default:               rd_ok   = 1'b0;       // unmapped reads give zero
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rd_ready <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= RESP_OKAY;
        end
        else
        begin
            rd_ready <= 1'b0;
            if (rvalid && s_axil_req.rready)
                rvalid <= 1'b0;
            if (rd_ready)
            begin
                rvalid <= 1'b1;
                rdata  <= rd_word;
                rresp  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            end
            else if (s_axil_req.arvalid && !rvalid)
                rd_ready <= 1'b1;
        end
    end

    always_comb
    begin
        s_axil_rsp.awready = wr_ready;
        s_axil_rsp.wready  = wr_ready;
        s_axil_rsp.bvalid  = bvalid;
        s_axil_rsp.bresp   = bresp;
        s_axil_rsp.arready = rd_ready;
        s_axil_rsp.rvalid  = rvalid;
        s_axil_rsp.rdata   = rdata;
        s_axil_rsp.rresp   = rresp;
        cfg.message        = msg_r;
        cfg.err_mask       = mask_r;
        cfg.rx_word        = rx_r;
        cfg.cmd            = cmd_r;
        cfg.start          = start_r;
    end

endmodule

/* source/bch_codec.sv */
`timescale 1ns/1ps

module bch_codec (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_req_t s_axil_req,
    output axil_pkg::axil_rsp_t s_axil_rsp
);

    axil_pkg::codec_cfg_t   cfg;
    bch_pkg::codec_status_t status;
    bch_pkg::codeword_t     codeword;
    bch_pkg::dec_result_t   result;
    bch_pkg::codeword_t     enc_codeword;
    bch_pkg::codeword_t     dec_word;
    bch_pkg::dec_result_t   dec_result;
    logic                   enc_start;
    logic                   enc_done;
    logic                   dec_start;
    logic                   dec_done;

    // --------------------
    // register block
    // --------------------
    axil_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .s_axil_req (s_axil_req),
        .s_axil_rsp (s_axil_rsp),
        .cfg        (cfg),
        .status     (status),
        .codeword   (codeword),
        .result     (result)
    );

    bch_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .cfg          (cfg),
        .enc_start    (enc_start),
        .enc_codeword (enc_codeword),
        .enc_done     (enc_done),
        .dec_start    (dec_start),
        .dec_word     (dec_word),
        .dec_result   (dec_result),
        .dec_done     (dec_done),
        .codeword     (codeword),
        .result       (result),
        .status       (status)
    );

    // --------------------
    // codec cores
    // --------------------
    bch_encoder u_enc (
        .clk      (clk),
        .rst      (rst),
        .start    (enc_start),
        .message  (cfg.message),
        .codeword (enc_codeword),
        .done     (enc_done)
    );

    bch_decoder u_dec (
        .clk     (clk),
        .rst     (rst),
        .start   (dec_start),
        .rx_word (dec_word),
        .result  (dec_result),
        .done    (dec_done)
    );

endmodule

/* source/bch_decoder.sv */
`timescale 1ns/1ps

module bch_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  bch_pkg::codeword_t   rx_word,
    output bch_pkg::dec_result_t result,
    output logic                 done
);

    typedef enum logic [1:0] {
        D_IDLE,
        D_LOCATE,
        D_SEARCH,
        D_QUOTIENT
    } dec_state_e;

    localparam int PAR = bch_pkg::CODE_N - bch_pkg::MSG_K;   // degree of g(x)

    // alpha^i, indexed by exponent
    localparam bch_pkg::gf_elem_t ALPHA [0:14] = '{
        4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'h6, 4'hc, 4'hb,
        4'h5, 4'ha, 4'h7, 4'he, 4'hf, 4'hd, 4'h9
    };

    // inverses, indexed by element value
    localparam bch_pkg::gf_elem_t INV [0:15] = '{
        4'h0, 4'h1, 4'h9, 4'he, 4'hd, 4'hb, 4'h7, 4'h6,
        4'hf, 4'h2, 4'hc, 4'h5, 4'ha, 4'h4, 4'h3, 4'h8
    };

    function automatic bch_pkg::gf_elem_t gf_mul(input bch_pkg::gf_elem_t a,
                                                 input bch_pkg::gf_elem_t b);
        bch_pkg::gf_elem_t acc;
        bch_pkg::gf_elem_t x;
        acc = '0;
        x   = a;
        for (int i = 0; i < 4; i++)
        begin
            if (b[i])
                acc = acc ^ x;
            x = {x[2:0], 1'b0} ^ (x[3] ? bch_pkg::FIELD_POLY[3:0] : 4'h0);
        end
        return acc;
    endfunction

    dec_state_e         state;
    logic [3:0]         pos;                // chien position
    bch_pkg::codeword_t rx_r;
    bch_pkg::codeword_t corr;
    bch_pkg::codeword_t rem;
    bch_pkg::message_t  quot;
    bch_pkg::gf_elem_t  syn1, syn3, syn5;
    bch_pkg::gf_elem_t  s1_r, s3_r, s5_r;
    bch_pkg::gf_elem_t  s2, s4, s1_cube;
    bch_pkg::gf_elem_t  loc_sig1, loc_sig2;
    bch_pkg::gf_elem_t  sig1, sig2;
    bch_pkg::gf_elem_t  z;
    bch_pkg::gf_elem_t  chien_val;
    logic [1:0]         loc_deg, deg;
    logic [1:0]         roots;
    logic               loc_bad, bad;
    logic               uncorr;

    // --------------------
    // syndromes S1 S3 S5
    // --------------------
    always_comb
    begin
        syn1 = '0;
        syn3 = '0;
        syn5 = '0;
        for (int i = 0; i < bch_pkg::CODE_N; i++)
        begin
            if (rx_word[i])
            begin
                syn1 = syn1 ^ ALPHA[i];
                syn3 = syn3 ^ ALPHA[(3 * i) % 15];
                syn5 = syn5 ^ ALPHA[(5 * i) % 15];
            end
        end
    end

    // --------------------
    // error locator
    // --------------------
    always_comb
    begin
        s2      = gf_mul(s1_r, s1_r);
        s4      = gf_mul(s2, s2);
        s1_cube = gf_mul(s2, s1_r);
        loc_sig1 = s1_r;
        loc_sig2 = '0;
        if (s1_r == '0 && s3_r == '0 && s5_r == '0)
            loc_deg = 2'd0;
        else if (s3_r == s1_cube)
            loc_deg = 2'd1;
        else
        begin
            loc_deg  = 2'd2;
            loc_sig2 = gf_mul(s3_r ^ s1_cube, INV[s1_r]);   // S1 = 0 leaves no roots
        end
        // newton identities for S4 and S5 must also hold
        loc_bad = ((s4 ^ gf_mul(loc_sig1, s3_r) ^ gf_mul(loc_sig2, s2)) != '0) ||
                  ((s5_r ^ gf_mul(loc_sig1, s4) ^ gf_mul(loc_sig2, s3_r)) != '0);
    end

    // roots of z^2 + sig1 z + sig2 are the error locations
    assign z         = ALPHA[pos];
    assign chien_val = gf_mul(z, z) ^ gf_mul(sig1, z) ^ sig2;

    // long division of the corrected word by g(x)
    always_comb
    begin
        rem  = corr;
        quot = '0;
        for (int i = bch_pkg::CODE_N - 1; i >= PAR; i--)
        begin
            if (rem[i])
            begin
                rem          = rem ^ (bch_pkg::codeword_t'(bch_pkg::GEN_POLY) << (i - PAR));
                quot[i-PAR]  = 1'b1;
            end
        end
        uncorr = bad || (roots != deg) || (rem != '0);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state  <= D_IDLE;
            pos    <= '0;
            done   <= 1'b0;
            result <= '0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                D_IDLE:
                    if (start)
                        state <= D_LOCATE;
                D_LOCATE:
                begin
                    pos   <= '0;
                    state <= D_SEARCH;
                end
                D_SEARCH:
                begin
                    pos <= pos + 4'd1;
                    if (pos == 4'(bch_pkg::CODE_N - 1))
                        state <= D_QUOTIENT;
                end
                default:
                begin
                    result.corrected     <= uncorr ? rx_r : corr;
                    result.message       <= uncorr ? '0 : quot;
                    result.err_count     <= uncorr ? 2'd3 : deg;
                    result.uncorrectable <= uncorr;
                    done                 <= 1'b1;
                    state                <= D_IDLE;
                end
            endcase
        end
    end

    // datapath, follows the control state
    always_ff @(posedge clk)
    begin
        case (state)
            D_IDLE:
                if (start)
                begin
                    rx_r <= rx_word;
                    s1_r <= syn1;
                    s3_r <= syn3;
                    s5_r <= syn5;
                end
            D_LOCATE:
            begin
                sig1  <= loc_sig1;
                sig2  <= loc_sig2;
                deg   <= loc_deg;
                bad   <= loc_bad;
                corr  <= rx_r;
                roots <= '0;
            end
            D_SEARCH:
                if (chien_val == '0)
                begin
                    corr[pos] <= ~corr[pos];
                    roots     <= roots + 2'd1;
                end
            default:
                roots <= roots;
        endcase
    end

endmodule

/* source/bch_encoder.sv */
`timescale 1ns/1ps

module bch_encoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  bch_pkg::message_t  message,
    output bch_pkg::codeword_t codeword,
    output logic               done
);

    bch_pkg::codeword_t product;

    // m(x) * g(x), one shifted copy of g per set message bit
    always_comb
    begin
        product = '0;
        for (int i = 0; i < bch_pkg::MSG_K; i++)
        begin
            if (message[i])
                product = product ^ (bch_pkg::codeword_t'(bch_pkg::GEN_POLY) << i);
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            done <= 1'b0;
        else
            done <= start;          // single cycle latency
    end

    always_ff @(posedge clk)
    begin
        if (start)
            codeword <= product;
    end

endmodule

/* source/bch_pkg.sv */
package bch_pkg;

    // --------------------
    // code and field
    // --------------------
    localparam int CODE_N = 15;
    localparam int MSG_K  = 5;

    // g(x) = x^10 + x^8 + x^5 + x^4 + x^2 + x + 1
    localparam logic [CODE_N-MSG_K:0] GEN_POLY = 11'b10100110111;

    localparam logic [4:0] FIELD_POLY = 5'b10011;     // x^4 + x + 1

    typedef logic [3:0]        gf_elem_t;
    typedef logic [CODE_N-1:0] codeword_t;
    typedef logic [MSG_K-1:0]  message_t;

    // --------------------
    // decoder and sequencer
    // --------------------
    typedef struct packed {
        codeword_t  corrected;
        message_t   message;
        logic [1:0] err_count;      // 3 means more errors than the code fixes
        logic       uncorrectable;
    } dec_result_t;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        ENCODING  = 3'd1,
        INJECTING = 3'd2,
        DECODING  = 3'd3,
        FINISHED  = 3'd4
    } seq_state_e;

    // busy lands in bit 0 of the STATUS register
    typedef struct packed {
        seq_state_e seq_state;
        logic [1:0] err_count;
        logic       uncorrectable;
        logic       done;
        logic       busy;
    } codec_status_t;

endpackage

/* source/bch_sequencer.sv */
`timescale 1ns/1ps

module bch_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  axil_pkg::codec_cfg_t   cfg,
    output logic                   enc_start,
    input  bch_pkg::codeword_t     enc_codeword,
    input  logic                   enc_done,
    output logic                   dec_start,
    output bch_pkg::codeword_t     dec_word,
    input  bch_pkg::dec_result_t   dec_result,
    input  logic                   dec_done,
    output bch_pkg::codeword_t     codeword,
    output bch_pkg::dec_result_t   result,
    output bch_pkg::codec_status_t status
);

    bch_pkg::seq_state_e state;
    axil_pkg::cmd_e      cmd_r;
    logic                done_r;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= bch_pkg::IDLE;
            cmd_r     <= axil_pkg::CMD_ENCODE;
            done_r    <= 1'b0;
            enc_start <= 1'b0;
            dec_start <= 1'b0;
            dec_word  <= '0;
            codeword  <= '0;
            result    <= '0;
        end
        else
        begin
            enc_start <= 1'b0;
            dec_start <= 1'b0;
            case (state)
                bch_pkg::IDLE, bch_pkg::FINISHED:
                    if (cfg.start)
                    begin
                        cmd_r  <= cfg.cmd;
                        done_r <= 1'b0;
                        if (cfg.cmd == axil_pkg::CMD_DECODE)
                        begin
                            dec_word  <= cfg.rx_word;       // software supplied word
                            dec_start <= 1'b1;
                            state     <= bch_pkg::DECODING;
                        end
                        else
                        begin
                            enc_start <= 1'b1;
                            state     <= bch_pkg::ENCODING;
                        end
                    end
                bch_pkg::ENCODING:
                    if (enc_done)
                    begin
                        codeword <= enc_codeword;
                        if (cmd_r == axil_pkg::CMD_LOOP)
                            state <= bch_pkg::INJECTING;
                        else
                        begin
                            done_r <= 1'b1;
                            state  <= bch_pkg::FINISHED;
                        end
                    end
                bch_pkg::INJECTING:
                begin
                    dec_word  <= codeword ^ cfg.err_mask;   // corrupt the clean codeword
                    dec_start <= 1'b1;
                    state     <= bch_pkg::DECODING;
                end
                bch_pkg::DECODING:
                    if (dec_done)
                    begin
                        result <= dec_result;
                        done_r <= 1'b1;
                        state  <= bch_pkg::FINISHED;
                    end
                default:
                    state <= bch_pkg::IDLE;
            endcase
        end
    end

    always_comb
    begin
        status.busy          = state inside {bch_pkg::ENCODING, bch_pkg::INJECTING,
                                             bch_pkg::DECODING};
        status.done          = done_r;
        status.uncorrectable = result.uncorrectable;
        status.err_count     = result.err_count;
        status.seq_state     = state;
    end

endmodule

/* verification/bch_codec_tb.sv */
`timescale 1ns/1ps

module bch_codec_tb;

    localparam int TIMEOUT  = 40;           // cycles per handshake wait
    localparam int POLL_MAX = 30;           // STATUS reads per operation
    localparam int PAR      = bch_pkg::CODE_N - bch_pkg::MSG_K;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic                clk;
    logic                rst;
    axil_pkg::axil_req_t req;
    axil_pkg::axil_rsp_t rsp;
    integer              seed;
    logic [1:0]          last_count;        // result of the latest decode
    logic                last_uncorr;

    bch_codec bch_codec_inst (
        .clk        (clk),
        .rst        (rst),
        .s_axil_req (req),
        .s_axil_rsp (rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run;
        $display("Finished with errors");
        $fatal(1);
    endtask

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_codeword(input string name, input bch_pkg::codeword_t exp,
                                  input bch_pkg::codeword_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_message(input string name, input bch_pkg::message_t exp,
                                 input bch_pkg::message_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input bch_pkg::codec_status_t exp,
                                input bch_pkg::codec_status_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp)
        begin
            $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    // --------------------
    // reference model
    // --------------------
    function automatic bch_pkg::codeword_t model_encode(input bch_pkg::message_t msg);
        bch_pkg::codeword_t prod;
        prod = '0;
        for (int j = 0; j <= PAR; j++)
        begin
            if (bch_pkg::GEN_POLY[j])
                prod = prod ^ (bch_pkg::codeword_t'(msg) << j);   // msg(x) * x^j
        end
        return prod;
    endfunction

    function automatic bch_pkg::message_t model_divide(input bch_pkg::codeword_t word);
        bch_pkg::codeword_t rem;
        bch_pkg::message_t  quot;
        rem  = word;
        quot = '0;
        for (int d = bch_pkg::MSG_K - 1; d >= 0; d--)
        begin
            if (rem[d + PAR])
            begin
                quot[d] = 1'b1;
                rem     = rem ^ (bch_pkg::codeword_t'(bch_pkg::GEN_POLY) << d);
            end
        end
        return quot;
    endfunction

    function automatic int count_bits(input bch_pkg::codeword_t v);
        int n;
        n = 0;
        for (int i = 0; i < bch_pkg::CODE_N; i++)
            n = n + int'(v[i]);
        return n;
    endfunction

    // random mask with exactly weight distinct set bits
    task automatic make_mask(input int weight, output bch_pkg::codeword_t mask);
        int pos;
        mask = '0;
        while (count_bits(mask) < weight)
        begin
            pos       = {$random(seed)} % bch_pkg::CODE_N;
            mask[pos] = 1'b1;
        end
    endtask

    // --------------------
    // bus tasks
    // --------------------
    task automatic step_with_timeout(inout int cycles, input string what);
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > TIMEOUT)
        begin
            $display("timeout while waiting for %s", what);
            abort_run();
        end
    endtask

    task automatic axil_write(input logic [axil_pkg::AXIL_ADDR_W-1:0] addr,
                              input logic [axil_pkg::AXIL_DATA_W-1:0] data,
                              output logic [1:0] resp);
        int cycles;
        @(posedge clk);
        #1;
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        req.wstrb   = '1;
        cycles      = 0;
        while (!rsp.awready)
            step_with_timeout(cycles, "awready");
        @(posedge clk);                     // handshake edge
        #1;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        req.bready  = 1'b1;
        cycles      = 0;
        while (!rsp.bvalid)
            step_with_timeout(cycles, "bvalid");
        resp = rsp.bresp;
        @(posedge clk);
        #1;
        req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [axil_pkg::AXIL_ADDR_W-1:0] addr,
                             output logic [axil_pkg::AXIL_DATA_W-1:0] data,
                             output logic [1:0] resp);
        int cycles;
        @(posedge clk);
        #1;
        req.arvalid = 1'b1;
        req.araddr  = addr;
        cycles      = 0;
        while (!rsp.arready)
            step_with_timeout(cycles, "arready");
        @(posedge clk);
        #1;
        req.arvalid = 1'b0;
        req.rready  = 1'b1;
        cycles      = 0;
        while (!rsp.rvalid)
            step_with_timeout(cycles, "rvalid");
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge clk);
        #1;
        req.rready = 1'b0;
    endtask

    task automatic write_reg(input logic [axil_pkg::AXIL_ADDR_W-1:0] addr,
                             input logic [axil_pkg::AXIL_DATA_W-1:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_resp("bresp", OKAY, resp);
    endtask

    task automatic read_reg(input logic [axil_pkg::AXIL_ADDR_W-1:0] addr,
                            output logic [axil_pkg::AXIL_DATA_W-1:0] data);
        logic [1:0] resp;
        axil_read(addr, data, resp);
        check_resp("rresp", OKAY, resp);
    endtask

    // --------------------
    // operations
    // --------------------
    task automatic wait_done(output bch_pkg::codec_status_t st);
        logic [31:0] data;
        int          polls;
        polls = 0;
        st    = '0;
        while (!st.done)
        begin
            polls++;
            if (polls > POLL_MAX)
            begin
                $display("codec never reported done in STATUS");
                abort_run();
            end
            read_reg(axil_pkg::STATUS, data);
            st = bch_pkg::codec_status_t'(data[7:0]);
        end
    endtask

    task automatic check_finished(input bch_pkg::codec_status_t st);
        bch_pkg::codec_status_t exp;
        exp.busy          = 1'b0;
        exp.done          = 1'b1;
        exp.uncorrectable = last_uncorr;
        exp.err_count     = last_count;
        exp.seq_state     = bch_pkg::FINISHED;
        check_status("status", exp, st);
    endtask

    // results of a decode of model_encode(msg) ^ mask
    task automatic check_decode(input bch_pkg::message_t msg, input bch_pkg::codeword_t mask,
                                input bch_pkg::codec_status_t st);
        logic [31:0]        data;
        bch_pkg::codeword_t clean;
        int                 weight;
        clean       = model_encode(msg);
        weight      = count_bits(mask);
        last_uncorr = weight > 2;
        last_count  = 2'(weight);           // 3 also marks a refused pattern
        check_finished(st);
        read_reg(axil_pkg::CORRECTED, data);
        if (weight > 2)
            check_codeword("corrected", clean ^ mask, data[14:0]);
        else
        begin
            check_codeword("corrected", clean, data[14:0]);
            read_reg(axil_pkg::DEC_MESSAGE, data);
            check_message("dec_message", model_divide(clean), data[4:0]);
        end
    endtask

    task automatic encode_trial;
        logic [31:0]            rnd;
        logic [31:0]            data;
        bch_pkg::codec_status_t st;
        rnd = $random(seed);
        write_reg(axil_pkg::MESSAGE, 32'(rnd[4:0]));
        write_reg(axil_pkg::COMMAND, 32'(axil_pkg::CMD_ENCODE));
        wait_done(st);
        check_finished(st);
        read_reg(axil_pkg::CODEWORD, data);
        check_codeword("codeword", model_encode(rnd[4:0]), data[14:0]);
    endtask

    task automatic loop_trial(input int weight, input logic busy_probe);
        logic [31:0]            rnd;
        logic [31:0]            data;
        logic [1:0]             resp;
        bch_pkg::codeword_t     mask;
        bch_pkg::codec_status_t st;
        rnd = $random(seed);
        make_mask(weight, mask);
        write_reg(axil_pkg::MESSAGE, 32'(rnd[4:0]));
        write_reg(axil_pkg::ERR_MASK, 32'(mask));
        write_reg(axil_pkg::COMMAND, 32'(axil_pkg::CMD_LOOP));
        if (busy_probe)
        begin
            read_reg(axil_pkg::STATUS, data);
            if (!data[0])
            begin
                $display("STATUS did not show busy while a loop command ran");
                abort_run();
            end
            axil_write(axil_pkg::COMMAND, 32'(axil_pkg::CMD_ENCODE), resp);
            check_resp("bresp", SLVERR, resp);      // refused, not queued
        end
        wait_done(st);
        read_reg(axil_pkg::CODEWORD, data);
        check_codeword("codeword", model_encode(rnd[4:0]), data[14:0]);
        check_decode(rnd[4:0], mask, st);
    endtask

    task automatic decode_trial(input int weight);
        logic [31:0]            rnd;
        bch_pkg::codeword_t     mask;
        bch_pkg::codec_status_t st;
        rnd = $random(seed);
        make_mask(weight, mask);
        write_reg(axil_pkg::RX_WORD, 32'(model_encode(rnd[4:0]) ^ mask));
        write_reg(axil_pkg::COMMAND, 32'(axil_pkg::CMD_DECODE));
        wait_done(st);
        check_decode(rnd[4:0], mask, st);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial
    begin
        logic [31:0] rnd;
        logic [31:0] data;
        logic [1:0]  resp;
        seed        = 47;
        last_count  = 2'd0;
        last_uncorr = 1'b0;
        req         = '0;
        rst         = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // register access after reset
        read_reg(axil_pkg::STATUS, data);
        check_status("status", '0, bch_pkg::codec_status_t'(data[7:0]));
        rnd = $random(seed);
        write_reg(axil_pkg::MESSAGE, 32'(rnd[4:0]));
        read_reg(axil_pkg::MESSAGE, data);
        check_message("message", rnd[4:0], data[4:0]);
        rnd = $random(seed);
        write_reg(axil_pkg::ERR_MASK, 32'(rnd[14:0]));
        read_reg(axil_pkg::ERR_MASK, data);
        check_codeword("err_mask", rnd[14:0], data[14:0]);
        axil_read(5'h02, data, resp);                   // unaligned, not mapped
        check_resp("rresp", SLVERR, resp);
        check_codeword("rdata", '0, data[14:0]);
        axil_write(5'h02, 32'h1, resp);
        check_resp("bresp", SLVERR, resp);
        axil_write(axil_pkg::STATUS, 32'h1, resp);      // read only
        check_resp("bresp", SLVERR, resp);
        axil_write(axil_pkg::COMMAND, 32'h0, resp);     // no such command
        check_resp("bresp", SLVERR, resp);

        for (int t = 0; t < 40; t++)
            encode_trial();
        for (int t = 0; t < 30; t++)
            loop_trial(t % 3, 1'b0);
        for (int t = 0; t < 10; t++)
            loop_trial(3, 1'b0);
        for (int t = 0; t < 20; t++)
            decode_trial(t % 3);
        loop_trial(2, 1'b1);

        $display("Finished with no errors");
        $finish;
    end

endmodule
